// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_arrays.sv
  - hdl/dcache_ctrl.sv
  - hdl/axi_line_mover.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/axi_mem_model.sv
      - bench/dcache_tb.sv

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model import dcache_pkg::*; #(
    parameter int addr_width = 32
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [addr_width-1:0]   araddr,
    input  logic [7:0]              arlen,
    input  logic [2:0]              arsize,
    input  logic [1:0]              arburst,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [data_width-1:0]   rdata,
    output logic                    rlast,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [addr_width-1:0]   awaddr,
    input  logic [7:0]              awlen,
    input  logic [2:0]              awsize,
    input  logic [1:0]              awburst,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [data_width-1:0]   wdata,
    input  logic [data_width/8-1:0] wstrb,
    input  logic                    wlast,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp
);

    localparam logic [data_width-1:0] fill_pattern = 64'h5a5a_5a5a_5a5a_5a5a;

    logic [data_width-1:0] mem [logic [addr_width-1:0]];  // Only written words live here
    logic [data_width-1:0] last_wbeats [beats_per_line];
    logic [addr_width-1:0] last_araddr;
    logic [addr_width-1:0] last_awaddr;
    logic [addr_width-1:0] rd_addr;
    logic [addr_width-1:0] wr_addr;
    logic [31:0]           rnd = 32'h8c69a0b1;
    logic                  rd_active;
    logic                  wr_active;
    logic                  b_pending;
    logic                  r_hold;
    logic                  b_hold;
    int                    rd_beats;
    int                    wr_beats;
    int                    ar_count = 0;
    int                    aw_count = 0;
    int                    protocol_errors = 0;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [data_width-1:0] read_mem(input logic [addr_width-1:0] a);
        return mem.exists(a) ? mem[a] : (data_width'(a) ^ fill_pattern);
    endfunction

    task automatic note_protocol_error(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        protocol_errors++;
    endtask

    assign bresp = 2'b00;

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    always @(posedge clock) begin
        r_hold = rvalid && !rready;  // Valid must stay up until taken
        b_hold = bvalid && !bready;
        if (reset) begin
            rd_active = 1'b0;
            wr_active = 1'b0;
            b_pending = 1'b0;
            rd_beats  = 0;
            wr_beats  = 0;
        end else begin
            if (arvalid && arready) begin
                assert (arlen == axi_len_line && arsize == axi_size_word &&
                        arburst == axi_burst_incr)
                    else note_protocol_error($sformatf("AR fields len %0d size %0d burst %0d",
                                                       arlen, arsize, arburst));
                last_araddr = araddr;
                rd_addr     = araddr;
                rd_beats    = 0;
                rd_active   = 1'b1;
                ar_count++;
            end
            if (rvalid && rready) begin
                rd_beats++;
                if (rlast)
                    rd_active = 1'b0;
            end
            if (awvalid && awready) begin
                assert (awlen == axi_len_line && awsize == axi_size_word &&
                        awburst == axi_burst_incr)
                    else note_protocol_error($sformatf("AW fields len %0d size %0d burst %0d",
                                                       awlen, awsize, awburst));
                last_awaddr = awaddr;
                wr_addr     = awaddr;
                wr_beats    = 0;
                wr_active   = 1'b1;
                aw_count++;
            end
            if (wvalid && wready) begin
                assert (wstrb == strb_full && wlast == (wr_beats == beats_per_line - 1))
                    else note_protocol_error($sformatf("W beat %0d strobe %h last %b",
                                                       wr_beats, wstrb, wlast));
                mem[addr_width'(wr_addr + 8 * wr_beats)] = wdata;
                if (wr_beats < beats_per_line)
                    last_wbeats[wr_beats] = wdata;
                wr_beats++;
                if (wlast) begin
                    wr_active = 1'b0;
                    b_pending = 1'b1;
                end
            end
            if (bvalid && bready)
                b_pending = 1'b0;
        end
        #1;
        rnd = next_random(rnd);
        if (reset) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
        end else begin
            arready = !rd_active && rnd[0];
            awready = !wr_active && !b_pending && rnd[7];
            wready  = wr_active && rnd[13];  // Random W stalls
            if (!r_hold) begin
                rvalid = rd_active && rnd[19];
                rdata  = read_mem(addr_width'(rd_addr + 8 * rd_beats));
                rlast  = (rd_beats == beats_per_line - 1);
            end
            if (!b_hold)
                bvalid = b_pending && rnd[26];
        end
    end

    a_ar_stable: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else note_protocol_error("AR request dropped or changed before arready");

    a_aw_stable: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else note_protocol_error("AW request dropped or changed before awready");

    a_w_stable: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else note_protocol_error("W beat dropped or changed before wready");

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 3
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Release just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int sets       = 4;
    localparam int ways       = 4;
    localparam int addr_width = 32;
    localparam int set_stride = sets << offset_width;  // Same set, next tag
    localparam logic [addr_width-1:0] line_mask =
        {{(addr_width - offset_width){1'b1}}, {offset_width{1'b0}}};
    localparam logic [data_width-1:0] fill_pattern = 64'h5a5a_5a5a_5a5a_5a5a;
    localparam logic [addr_width-1:0] addr_a = 32'h0000_1048;  // Set 1
    localparam logic [addr_width-1:0] addr_b = 32'h0000_2090;  // Set 2
    localparam logic [addr_width-1:0] addr_c = 32'h0000_3018;  // Set 0

    logic                    clock;
    logic                    reset;
    logic                    req_valid;
    logic                    req_write;
    logic [addr_width-1:0]   req_addr;
    logic [data_width-1:0]   req_wdata;
    logic                    resp_valid;
    logic [data_width-1:0]   resp_rdata;
    logic                    arvalid;
    logic                    arready;
    logic [addr_width-1:0]   araddr;
    logic [7:0]              arlen;
    logic [2:0]              arsize;
    logic [1:0]              arburst;
    logic                    rvalid;
    logic                    rready;
    logic [data_width-1:0]   rdata;
    logic                    rlast;
    logic                    awvalid;
    logic                    awready;
    logic [addr_width-1:0]   awaddr;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic [1:0]              awburst;
    logic                    wvalid;
    logic                    wready;
    logic [data_width-1:0]   wdata;
    logic [data_width/8-1:0] wstrb;
    logic                    wlast;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;

    logic [data_width-1:0] ref_mem [logic [addr_width-1:0]];  // What the processor should see
    int errors = 0;
    int start_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    clock_gen #(.period(100), .reset_cycles(3)) clock_i (.clock, .reset);

    axi_mem_model #(.addr_width(addr_width)) mem_i (.*);

    dcache_top #(.sets(sets), .ways(ways), .addr_width(addr_width)) dut_i (.*);

    function automatic logic [data_width-1:0] expected_word(input logic [addr_width-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : (data_width'(a) ^ fill_pattern);
    endfunction

    task automatic flag_error(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = errors - start_errors;
        tests_run++;
        if (fails != 0)
            tests_failed++;
        $display("%-14s %s", name, (fails == 0) ? "passed" : "failed");
        start_errors = errors;
    endtask

    // One request, held until resp_valid; latency counts cycles from the drive
    task automatic access(input logic write, input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] wdata,
                          output int latency, output logic ar_seen);
        logic [data_width-1:0] exp;
        exp     = expected_word(addr);
        latency = 0;
        ar_seen = 1'b0;
        @(posedge clock);
        #1;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        do begin
            @(negedge clock);
            latency++;
            ar_seen |= arvalid;
            if (latency > 2000) begin
                $display("Timeout: no response to the access at address %h", addr);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end while (!resp_valid);
        if (write)
            ref_mem[addr] = wdata;
        else
            assert (resp_rdata === exp)
                else flag_error($sformatf("read %h returned %h, expected %h",
                                          addr, resp_rdata, exp));
        @(posedge clock);
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        int   lat;
        int   cycles;
        int   n_ar;
        int   n_aw;
        logic ar_seen;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;

        // Outputs quiet in reset and one cycle beyond
        @(posedge clock);  // First reset edge
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            assert (!(resp_valid || arvalid || rready || awvalid || wvalid || wlast || bready))
                else flag_error("response or AXI output high around reset");
            if (cycles > 20) begin
                $display("Timeout: reset never released");
                $display("Simulation finished: FAIL");
                $finish;
            end
        end while (reset);
        end_test("reset");

        n_ar = mem_i.ar_count;
        access(1'b0, addr_a, '0, lat, ar_seen);
        assert (mem_i.ar_count == n_ar + 1 && mem_i.last_araddr == (addr_a & line_mask))
            else flag_error($sformatf("fill gave %0d AR bursts, last at %h",
                                      mem_i.ar_count - n_ar, mem_i.last_araddr));
        end_test("read_miss");

        n_ar = mem_i.ar_count;
        access(1'b0, addr_a + 8, '0, lat, ar_seen);
        assert (lat == 2 && !ar_seen && mem_i.ar_count == n_ar)
            else flag_error($sformatf("hit took %0d cycles, arvalid seen %b", lat - 1, ar_seen));
        end_test("read_hit");

        n_aw = mem_i.aw_count;
        access(1'b1, addr_a, 64'h1111_2222_3333_4444, lat, ar_seen);  // Write hit
        access(1'b1, addr_b, 64'h5555_6666_7777_8888, lat, ar_seen);  // Write miss
        access(1'b0, addr_a, '0, lat, ar_seen);
        access(1'b0, addr_b, '0, lat, ar_seen);
        access(1'b0, addr_b + 16, '0, lat, ar_seen);
        assert (mem_i.aw_count == n_aw)
            else flag_error($sformatf("%0d write bursts while lines resident",
                                      mem_i.aw_count - n_aw));
        end_test("write_back");

        // Dirty line in way 0, then one tag more than the set holds
        n_aw = mem_i.aw_count;
        access(1'b1, addr_c, 64'h9999_aaaa_bbbb_cccc, lat, ar_seen);
        for (int k = 1; k <= ways; k++)
            access(1'b0, addr_c + k * set_stride, '0, lat, ar_seen);
        assert (mem_i.aw_count == n_aw + 1 && mem_i.last_awaddr == (addr_c & line_mask))
            else flag_error($sformatf("%0d write bursts, last at %h",
                                      mem_i.aw_count - n_aw, mem_i.last_awaddr));
        for (int i = 0; i < beats_per_line; i++)
            assert (mem_i.last_wbeats[i] === expected_word((addr_c & line_mask) + 8 * i))
                else flag_error($sformatf("write-back beat %0d is %h, expected %h", i,
                                          mem_i.last_wbeats[i],
                                          expected_word((addr_c & line_mask) + 8 * i)));
        n_ar = mem_i.ar_count;
        access(1'b0, addr_c, '0, lat, ar_seen);
        assert (mem_i.ar_count == n_ar + 1)
            else flag_error("evicted line read back without a refill");
        end_test("eviction");

        assert (mem_i.protocol_errors == 0)
            else flag_error($sformatf("%0d AXI protocol violations", mem_i.protocol_errors));
        end_test("axi_protocol");

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== dcache.f ====
hdl/dcache_pkg.sv
hdl/dcache_arrays.sv
hdl/dcache_ctrl.sv
hdl/axi_line_mover.sv
hdl/dcache_top.sv
bench/clock_gen.sv
bench/axi_mem_model.sv
bench/dcache_tb.sv

// ==== hdl/axi_line_mover.sv ====
`timescale 1ns/1ps

module axi_line_mover import dcache_pkg::*; #(
    parameter int addr_width = 32
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    read_start,
    input  logic [addr_width-1:0]   read_addr,
    input  logic                    write_start,
    input  logic [addr_width-1:0]   write_addr,
    input  logic [line_width-1:0]   write_line,
    output logic                    done,
    output logic [line_width-1:0]   fill_line,
    output logic                    arvalid,
    input  logic                    arready,
    output logic [addr_width-1:0]   araddr,
    output logic [7:0]              arlen,
    output logic [2:0]              arsize,
    output logic [1:0]              arburst,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [data_width-1:0]   rdata,
    input  logic                    rlast,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [addr_width-1:0]   awaddr,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [data_width-1:0]   wdata,
    output logic [data_width/8-1:0] wstrb,
    output logic                    wlast,
    input  logic                    bvalid,
    output logic                    bready
);

    localparam int beat_width = $clog2(beats_per_line);
    localparam logic [beat_width-1:0] last_beat = beat_width'(beats_per_line - 1);

    typedef enum logic [2:0] {mv_idle, mv_ar, mv_r, mv_aw, mv_w, mv_b} mover_state_t;

    mover_state_t          state_q;
    logic [beat_width-1:0] beat_q;  // W beat index into write_line
    logic [addr_width-1:0] addr_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= mv_idle;
            beat_q  <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                mv_idle: begin
                    beat_q <= '0;
                    if (read_start)
                        state_q <= mv_ar;
                    else if (write_start)
                        state_q <= mv_aw;
                end
                mv_ar: if (arready) state_q <= mv_r;
                mv_r: begin
                    if (rvalid && rlast) begin
                        state_q <= mv_idle;
                        done    <= 1'b1;
                    end
                end
                mv_aw: if (awready) state_q <= mv_w;
                mv_w: begin
                    if (wready) begin
                        beat_q <= beat_q + 1'b1;
                        if (wlast)
                            state_q <= mv_b;
                    end
                end
                mv_b: begin
                    if (bvalid) begin
                        state_q <= mv_idle;
                        done    <= 1'b1;
                    end
                end
                default: state_q <= mv_idle;
            endcase
        end
    end

    // Line-aligned burst address, and R beats shifted in from the top
    always_ff @(posedge clock) begin
        if (state_q == mv_idle && (read_start || write_start))
            addr_q <= {(read_start ? read_addr[addr_width-1:offset_width]
                                   : write_addr[addr_width-1:offset_width]),
                       {offset_width{1'b0}}};
        if (rvalid && rready)
            fill_line <= {rdata, fill_line[line_width-1:data_width]};
    end

    assign arvalid = (state_q == mv_ar);
    assign araddr  = addr_q;
    assign arlen   = axi_len_line;
    assign arsize  = axi_size_word;
    assign arburst = axi_burst_incr;
    assign rready  = (state_q == mv_r);
    assign awvalid = (state_q == mv_aw);
    assign awaddr  = addr_q;
    assign awlen   = axi_len_line;
    assign awsize  = axi_size_word;
    assign awburst = axi_burst_incr;
    assign wvalid  = (state_q == mv_w);
    assign wdata   = write_line[beat_q*data_width +: data_width];
    assign wstrb   = strb_full;
    assign wlast   = (state_q == mv_w) && (beat_q == last_beat);
    assign bready  = (state_q == mv_b);

    a_wlast_valid: assert property (@(posedge clock) disable iff (reset) wlast |-> wvalid);

endmodule

// ==== hdl/dcache_arrays.sv ====
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; #(
    parameter int sets       = 4,
    parameter int ways       = 4,
    parameter int addr_width = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [addr_width-1:0] lookup_addr,
    input  logic                  word_write,
    input  logic [data_width-1:0] word_wdata,
    input  logic                  line_install,
    input  logic [line_width-1:0] fill_line,
    output logic                  hit,
    output logic [data_width-1:0] read_word,
    output logic                  victim_dirty,
    output logic [addr_width-1:0] victim_addr,
    output logic [line_width-1:0] victim_line
);

    localparam int index_width = $clog2(sets);
    localparam int tag_width   = addr_width - index_width - offset_width;
    localparam int word_width  = $clog2(beats_per_line);
    localparam int way_width   = $clog2(ways);

    logic [tag_width-1:0]   tag_q   [sets][ways];
    logic [line_width-1:0]  data_q  [sets][ways];
    logic [ways-1:0]        valid_q [sets];
    logic [ways-1:0]        dirty_q [sets];
    logic [way_width-1:0]   rr_q;  // Round-robin pointer, shared by all sets

    logic [index_width-1:0] index;
    logic [tag_width-1:0]   tag;
    logic [word_width-1:0]  word;
    logic [ways-1:0]        match;
    logic [way_width-1:0]   hit_way;
    logic [way_width-1:0]   victim_way;
    logic                   set_full;

    assign tag   = lookup_addr[addr_width-1 -: tag_width];
    assign index = lookup_addr[offset_width +: index_width];
    assign word  = lookup_addr[offset_width-1 -: word_width];  // 64-bit word in the line

    // Scan from the top so the lowest invalid way is chosen
    always_comb begin
        hit_way    = '0;
        victim_way = rr_q;
        for (int w = ways - 1; w >= 0; w--) begin
            match[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (match[w])
                hit_way = way_width'(w);
            if (!valid_q[index][w])
                victim_way = way_width'(w);
        end
    end

    assign set_full     = &valid_q[index];
    assign hit          = |match;
    assign read_word    = data_q[index][hit_way][word*data_width +: data_width];
    assign victim_line  = data_q[index][victim_way];
    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_addr  = {tag_q[index][victim_way], index, {offset_width{1'b0}}};

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_q <= '0;
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (line_install) begin
            valid_q[index][victim_way] <= 1'b1;
            dirty_q[index][victim_way] <= 1'b0;  // Fresh line is clean
            if (set_full)
                rr_q <= rr_q + 1'b1;  // A valid line was replaced
        end else if (word_write) begin
            dirty_q[index][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (line_install) begin
            tag_q[index][victim_way]  <= tag;
            data_q[index][victim_way] <= fill_line;
        end else if (word_write) begin
            data_q[index][hit_way][word*data_width +: data_width] <= word_wdata;
        end
    end

    a_one_match: assert property (@(posedge clock) disable iff (reset) $onehot0(match));

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int addr_width = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic                  hit,
    input  logic [data_width-1:0] read_word,
    input  logic                  victim_dirty,
    input  logic                  mover_done,
    output logic                  resp_valid,
    output logic [data_width-1:0] resp_rdata,
    output logic                  word_write,
    output logic                  line_install,
    output logic                  read_start,
    output logic                  write_start
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        lookup;  // Request seen while idle
    logic        miss;

    // Address must hold at least a tag bit and a set bit above the line offset
    if (addr_width < offset_width + 2) begin : g_addr_check
        $error("dcache_ctrl: addr_width too small for the line geometry");
    end

    assign lookup       = (state_q == st_idle) && req_valid;
    assign miss         = lookup && !hit;
    assign word_write   = lookup && hit && req_write;
    assign write_start  = miss && victim_dirty;
    // Fill starts at once on a clean miss, or right after the write-back
    assign read_start   = (miss && !victim_dirty) || ((state_q == st_evict) && mover_done);
    assign line_install = (state_q == st_install);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (lookup && hit)
                    state_d = st_respond;
                else if (write_start)
                    state_d = st_evict;
                else if (read_start)
                    state_d = st_fill;
            end
            st_respond: begin
                state_d = st_idle;  // Requester may change the request after this
            end
            st_evict: begin
                if (mover_done)
                    state_d = st_fill;
            end
            st_fill: begin
                if (mover_done)
                    state_d = st_install;
            end
            st_install: begin
                state_d = st_idle;  // Retried request hits from idle
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q    <= st_idle;
            resp_valid <= 1'b0;
        end else begin
            state_q    <= state_d;
            resp_valid <= lookup && hit;
        end
    end

    // Response data, meaningful for reads only
    always_ff @(posedge clock) begin
        if (lookup && hit)
            resp_rdata <= read_word;
    end

    a_start_excl: assert property (@(posedge clock) disable iff (reset)
        !(read_start && write_start));

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // Processor word and AXI data beat share one width
    localparam int data_width     = 64;
    localparam int beats_per_line = 8;
    localparam int line_width     = data_width * beats_per_line;
    localparam int offset_width   = $clog2(line_width / 8);  // Byte offset inside a line

    // AXI burst fields for moving one full line
    localparam logic [7:0] axi_len_line   = 8'(beats_per_line - 1);
    localparam logic [2:0] axi_size_word  = 3'd3;  // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'b01;

    localparam logic [data_width/8-1:0] strb_full = '1;

    // Controller sequencing
    typedef enum logic [2:0] {
        st_idle,     // Waiting for a request, hits answered from here
        st_respond,  // resp_valid high, request still held
        st_evict,    // Dirty victim going out
        st_fill,     // Line coming in
        st_install   // Filled line written into the arrays
    } ctrl_state_t;

endpackage

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int sets       = 4,
    parameter int ways       = 4,
    parameter int addr_width = 32
) (
    input  logic                    clock,
    input  logic                    reset,
    // Processor port
    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic [addr_width-1:0]   req_addr,
    input  logic [data_width-1:0]   req_wdata,
    output logic                    resp_valid,
    output logic [data_width-1:0]   resp_rdata,
    // AXI read channels
    output logic                    arvalid,
    input  logic                    arready,
    output logic [addr_width-1:0]   araddr,
    output logic [7:0]              arlen,
    output logic [2:0]              arsize,
    output logic [1:0]              arburst,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [data_width-1:0]   rdata,
    input  logic                    rlast,
    // AXI write channels
    output logic                    awvalid,
    input  logic                    awready,
    output logic [addr_width-1:0]   awaddr,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [data_width-1:0]   wdata,
    output logic [data_width/8-1:0] wstrb,
    output logic                    wlast,
    input  logic                    bvalid,
    output logic                    bready,
    input  logic [1:0]              bresp   // Write response is not checked
);

    logic                  hit;
    logic [data_width-1:0] read_word;
    logic                  victim_dirty;
    logic [addr_width-1:0] victim_addr;
    logic [line_width-1:0] victim_line;
    logic [line_width-1:0] fill_line;
    logic                  word_write;
    logic                  line_install;
    logic                  read_start;
    logic                  write_start;
    logic                  mover_done;

    dcache_ctrl #(.addr_width(addr_width)) ctrl_i (
        .clock, .reset, .req_valid, .req_write, .hit, .read_word, .victim_dirty,
        .mover_done, .resp_valid, .resp_rdata, .word_write, .line_install,
        .read_start, .write_start
    );

    dcache_arrays #(.sets(sets), .ways(ways), .addr_width(addr_width)) arrays_i (
        .clock, .reset, .lookup_addr(req_addr), .word_write, .word_wdata(req_wdata),
        .line_install, .fill_line, .hit, .read_word, .victim_dirty, .victim_addr,
        .victim_line
    );

    axi_line_mover #(.addr_width(addr_width)) mover_i (
        .clock, .reset, .read_start, .read_addr(req_addr), .write_start,
        .write_addr(victim_addr), .write_line(victim_line), .done(mover_done), .fill_line,
        .arvalid, .arready, .araddr, .arlen, .arsize, .arburst, .rvalid, .rready, .rdata,
        .rlast, .awvalid, .awready, .awaddr, .awlen, .awsize, .awburst, .wvalid, .wready,
        .wdata, .wstrb, .wlast, .bvalid, .bready
    );

endmodule
